//--- hw/debug_shell_top.sv
`timescale 1ns/1ns
`default_nettype none

module debug_shell_top #(
  parameter int cnt_w = 32,
  parameter int scan_div = 25000
) (
  input logic clk,
  input logic rst,
  input logic wr_en,
  input logic rd_en,
  input logic [soc_debug_pkg::addr_w-1:0] addr,
  input logic [soc_debug_pkg::data_w-1:0] wr_data,
  input logic debug,
  output logic [soc_debug_pkg::data_w-1:0] rd_data,
  output logic rd_valid,
  output logic [6:0] sev_out,
  output logic [7:0] an,
  output logic [soc_debug_pkg::led_w-1:0] led
);

  import soc_debug_pkg::*;

  logic cnt_en;
  logic cnt_clear;
  logic [cnt_w-1:0] cnt_value;
  logic cnt_ovflw;
  logic scan_tick;
  disp_word_u disp_word;

  // Digit rate enable
  tick_gen #(
    .div(scan_div)
  ) i_tick_gen (
    .clk (clk),
    .rst (rst),
    .tick(scan_tick)
  );

  interval_counter #(
    .width(cnt_w)
  ) i_interval_counter (
    .clk  (clk),
    .rst  (rst),
    .en   (cnt_en),
    .clear(cnt_clear),
    .value(cnt_value),
    .ovflw(cnt_ovflw)
  );

  mmio_regs #(
    .cnt_w(cnt_w)
  ) i_mmio_regs (
    .clk      (clk),
    .rst      (rst),
    .wr_en    (wr_en),
    .rd_en    (rd_en),
    .debug    (debug),
    .addr     (addr),
    .wr_data  (wr_data),
    .cnt_value(cnt_value),
    .cnt_ovflw(cnt_ovflw),
    .rd_data  (rd_data),
    .rd_valid (rd_valid),
    .cnt_en   (cnt_en),
    .cnt_clear(cnt_clear),
    .disp_word(disp_word),
    .led      (led)
  );

  seg_scanner i_seg_scanner (
    .clk      (clk),
    .rst      (rst),
    .tick     (scan_tick),
    .disp_word(disp_word),
    .an       (an),
    .sev_out  (sev_out)
  );

endmodule : debug_shell_top

`default_nettype wire

//--- hw/interval_counter.sv
`timescale 1ns/1ns
`default_nettype none

module interval_counter #(
  parameter int width = 32
) (
  input logic clk,
  input logic rst,
  input logic en,
  input logic clear,
  output logic [width-1:0] value,
  output logic ovflw
);

  logic at_max;

  // All ones means the next increment wraps
  assign at_max = (value == {width{1'b1}});

  always_ff @(posedge clk) begin
    if (rst) begin
      value <= '0;
    end else if (clear) begin
      value <= '0;
    end else if (en) begin
      value <= value + 1'b1;
    end
  end

  // Sticky until cleared
  always_ff @(posedge clk) begin
    if (rst) begin
      ovflw <= 1'b0;
    end else if (clear) begin
      ovflw <= 1'b0;
    end else if (en && at_max) begin
      ovflw <= 1'b1;
    end
  end

endmodule : interval_counter

`default_nettype wire

//--- hw/mmio_regs.sv
`timescale 1ns/1ns
`default_nettype none

module mmio_regs #(
  parameter int cnt_w = 32
) (
  input logic clk,
  input logic rst,
  input logic wr_en,
  input logic rd_en,
  input logic debug,
  input logic [soc_debug_pkg::addr_w-1:0] addr,
  input logic [soc_debug_pkg::data_w-1:0] wr_data,
  input logic [cnt_w-1:0] cnt_value,
  input logic cnt_ovflw,
  output logic [soc_debug_pkg::data_w-1:0] rd_data,
  output logic rd_valid,
  output logic cnt_en,
  output logic cnt_clear,
  output soc_debug_pkg::disp_word_u disp_word,
  output logic [soc_debug_pkg::led_w-1:0] led
);

  import soc_debug_pkg::*;

  logic [data_w-1:0] disp_reg;
  logic [led_w-1:0] led_reg;
  logic [data_w-1:0] rd_mux;
  logic [data_w-1:0] cnt_ext;

  assign cnt_ext = data_w'(cnt_value);

  // Register writes
  always_ff @(posedge clk) begin
    if (rst) begin
      disp_reg <= '0;
      led_reg <= '0;
      cnt_en <= 1'b0;
    end else if (wr_en) begin
      case (addr)
        addr_disp: disp_reg <= wr_data;
        addr_led: led_reg <= wr_data[led_w-1:0];
        addr_cnt_ctrl: cnt_en <= wr_data[ctrl_en_bit];
        default: ;
      endcase
    end
  end

  // Clear is a single-cycle pulse after the control write
  always_ff @(posedge clk) begin
    if (rst) begin
      cnt_clear <= 1'b0;
    end else begin
      cnt_clear <= wr_en && (addr == addr_cnt_ctrl) && wr_data[ctrl_clear_bit];
    end
  end

  always_comb begin
    rd_mux = '0;
    case (addr)
      addr_disp: rd_mux = disp_reg;
      addr_led: rd_mux = data_w'(led_reg);
      addr_cnt_ctrl: rd_mux[ctrl_en_bit] = cnt_en;
      addr_cnt: rd_mux = cnt_ext;
      addr_status: rd_mux[status_ovflw_bit] = cnt_ovflw;
      default: rd_mux = '0;
    endcase
  end

  // Read data samples pre-write state
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= rd_en;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= rd_mux;
    end
  end

  // Debug mode shows the live count
  assign disp_word.word = debug ? cnt_ext : disp_reg;

  // LED 0 reports overflow
  assign led = {led_reg[led_w-1:1], cnt_ovflw};

endmodule : mmio_regs

`default_nettype wire

//--- hw/seg_scanner.sv
`timescale 1ns/1ns
`default_nettype none

module seg_scanner (
  input logic clk,
  input logic rst,
  input logic tick,
  input soc_debug_pkg::disp_word_u disp_word,
  output logic [7:0] an,
  output logic [6:0] sev_out
);

  logic [2:0] idx;
  logic [2:0] idx_next;

  // Segments a..g, active low
  function automatic logic [6:0] hex_seg(input logic [3:0] nib);
    logic [6:0] seg;
    case (nib)
      4'h0: seg = 7'b0000001;
      4'h1: seg = 7'b1001111;
      4'h2: seg = 7'b0010010;
      4'h3: seg = 7'b0000110;
      4'h4: seg = 7'b1001100;
      4'h5: seg = 7'b0100100;
      4'h6: seg = 7'b0100000;
      4'h7: seg = 7'b0001111;
      4'h8: seg = 7'b0000000;
      4'h9: seg = 7'b0000100;
      4'ha: seg = 7'b0001000;
      4'hb: seg = 7'b1100000;
      4'hc: seg = 7'b0110001;
      4'hd: seg = 7'b1000010;
      4'he: seg = 7'b0110000;
      4'hf: seg = 7'b0111000;
      default: seg = 7'b1111111;
    endcase
    return seg;
  endfunction

  // Wraps 7 -> 0 naturally
  assign idx_next = tick ? idx + 3'd1 : idx;

  always_ff @(posedge clk) begin
    if (rst) begin
      idx <= 3'd0;
    end else begin
      idx <= idx_next;
    end
  end

  // Anode and segments move together, segments refresh every cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      an <= 8'b1111_1110;
      sev_out <= hex_seg(disp_word.nib[0]);
    end else begin
      an <= ~(8'b0000_0001 << idx_next);
      sev_out <= hex_seg(disp_word.nib[idx_next]);
    end
  end

endmodule : seg_scanner

`default_nettype wire

//--- hw/soc_debug_pkg.sv
`default_nettype none

package soc_debug_pkg;

  // Bus geometry
  localparam int addr_w = 4;
  localparam int data_w = 32;
  localparam int led_w = 16;

  // Display word is split into hex digits
  localparam int nib_n = data_w / 4;

  // Register map
  localparam logic [addr_w-1:0] addr_disp = 4'd0;
  localparam logic [addr_w-1:0] addr_led = 4'd1;
  localparam logic [addr_w-1:0] addr_cnt_ctrl = 4'd2;
  localparam logic [addr_w-1:0] addr_cnt = 4'd3;
  localparam logic [addr_w-1:0] addr_status = 4'd4;

  // Counter control bits
  localparam int ctrl_en_bit = 0;
  localparam int ctrl_clear_bit = 1;

  // Status bits
  localparam int status_ovflw_bit = 0;

  // One display word, seen whole or as hex digits
  typedef union packed {
    logic [data_w-1:0] word;
    logic [nib_n-1:0][3:0] nib;
  } disp_word_u;

endpackage : soc_debug_pkg

`default_nettype wire

//--- hw/tick_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tick_gen #(
  parameter int div = 25000
) (
  input logic clk,
  input logic rst,
  output logic tick
);

  // Guard against a one-bit divide
  localparam int cw = (div > 1) ? $clog2(div) : 1;

  logic [cw-1:0] count;
  logic wrap;

  assign wrap = (count == cw'(div - 1));

  always_ff @(posedge clk) begin
    if (rst) begin
      count <= '0;
      tick <= 1'b0;
    end else begin
      count <= wrap ? '0 : count + 1'b1;
      // Pulse lands one cycle after the wrap value
      tick <= wrap;
    end
  end

endmodule : tick_gen

`default_nettype wire

//--- project.f
hw/soc_debug_pkg.sv
hw/tick_gen.sv
hw/interval_counter.sv
hw/mmio_regs.sv
hw/seg_scanner.sv
hw/debug_shell_top.sv
verification/tb_debug_shell.sv

//--- verification/tb_debug_shell.sv
`timescale 1ns/1ns
`default_nettype none

module tb_debug_shell;

  import soc_debug_pkg::*;

  localparam int cnt_w = 8;
  localparam int scan_div = 4;
  localparam int max_entries = 96;

  // Table operations
  localparam int op_wr = 0;
  localparam int op_rd = 1;
  localparam int op_idle = 2;
  localparam int op_scan = 3;
  localparam int op_led = 4;

  logic clk;
  logic rst;
  logic wr_en;
  logic rd_en;
  logic [addr_w-1:0] addr;
  logic [data_w-1:0] wr_data;
  logic debug;
  logic [data_w-1:0] rd_data;
  logic rd_valid;
  logic [6:0] sev_out;
  logic [7:0] an;
  logic [led_w-1:0] led;

  int op_t [max_entries];
  logic [addr_w-1:0] addr_t [max_entries];
  logic [data_w-1:0] data_t [max_entries];
  logic dbg_t [max_entries];
  logic [data_w-1:0] exp_t [max_entries];
  int n_entries = 0;

  logic [6:0] seg_table [16];
  integer seed = 32'hb5a7_146f;
  int cycles = 0;
  int limit = 0;

  debug_shell_top #(
    .cnt_w(cnt_w),
    .scan_div(scan_div)
  ) i_dut (
    .clk     (clk),
    .rst     (rst),
    .wr_en   (wr_en),
    .rd_en   (rd_en),
    .addr    (addr),
    .wr_data (wr_data),
    .debug   (debug),
    .rd_data (rd_data),
    .rd_valid(rd_valid),
    .sev_out (sev_out),
    .an      (an),
    .led     (led)
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (limit > 0 && cycles >= limit) begin
      $display("Run timed out after %0d cycles before the table finished", cycles);
      $display("test failed");
      $fatal(1, "timeout");
    end
  end

  task automatic check_val(input string name, input logic [31:0] exp_v,
                           input logic [31:0] act_v);
    if (exp_v !== act_v) begin
      $display("ERR %0t %s expected %h actual %h", $time, name, exp_v, act_v);
      $display("test failed");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  // Segments a..g from the MSB, active low
  task automatic init_seg_table();
    seg_table[0] = 7'b0000001;
    seg_table[1] = 7'b1001111;
    seg_table[2] = 7'b0010010;
    seg_table[3] = 7'b0000110;
    seg_table[4] = 7'b1001100;
    seg_table[5] = 7'b0100100;
    seg_table[6] = 7'b0100000;
    seg_table[7] = 7'b0001111;
    seg_table[8] = 7'b0000000;
    seg_table[9] = 7'b0000100;
    seg_table[10] = 7'b0001000;
    seg_table[11] = 7'b1100000;
    seg_table[12] = 7'b0110001;
    seg_table[13] = 7'b1000010;
    seg_table[14] = 7'b0110000;
    seg_table[15] = 7'b0111000;
  endtask

  // Digit i drives only anode bit i low
  function automatic logic [7:0] anode_for(input int i);
    logic [7:0] v;
    v = 8'hff;
    v[i] = 1'b0;
    return v;
  endfunction

  function automatic int low_bit_count(input logic [7:0] v);
    int n;
    n = 0;
    for (int i = 0; i < 8; i++) begin
      if (v[i] == 1'b0) n++;
    end
    return n;
  endfunction

  function automatic int low_bit_index(input logic [7:0] v);
    int idx;
    idx = 0;
    for (int i = 7; i >= 0; i--) begin
      if (v[i] == 1'b0) idx = i;
    end
    return idx;
  endfunction

  task automatic add_entry(input int op, input logic [addr_w-1:0] a,
                           input logic [data_w-1:0] d, input logic dbg,
                           input logic [data_w-1:0] e);
    op_t[n_entries] = op;
    addr_t[n_entries] = a;
    data_t[n_entries] = d;
    dbg_t[n_entries] = dbg;
    exp_t[n_entries] = e;
    n_entries++;
  endtask

  task automatic build_table();
    logic [data_w-1:0] d0;
    logic [data_w-1:0] d1;
    logic [data_w-1:0] d2;
    logic [data_w-1:0] l0;
    logic [data_w-1:0] l1;
    logic [data_w-1:0] w;
    d0 = $random(seed);
    d1 = $random(seed);
    d2 = $random(seed);
    l0 = $random(seed);
    l1 = $random(seed);
    w = $random(seed);
    // Everything reads zero out of reset
    add_entry(op_rd, addr_disp, 0, 0, 0);
    add_entry(op_rd, addr_led, 0, 0, 0);
    add_entry(op_rd, addr_cnt_ctrl, 0, 0, 0);
    add_entry(op_rd, addr_cnt, 0, 0, 0);
    add_entry(op_rd, addr_status, 0, 0, 0);
    add_entry(op_rd, 4'd7, 0, 0, 0);
    add_entry(op_rd, 4'd15, 0, 0, 0);
    add_entry(op_led, 0, 0, 0, 0);
    add_entry(op_wr, addr_disp, d0, 0, 0);
    add_entry(op_rd, addr_disp, 0, 0, d0);
    add_entry(op_wr, addr_disp, d1, 0, 0);
    add_entry(op_rd, addr_disp, 0, 0, d1);
    add_entry(op_wr, addr_disp, d2, 0, 0);
    add_entry(op_rd, addr_disp, 0, 0, d2);
    // LED register keeps 16 bits, LED 0 belongs to overflow
    add_entry(op_wr, addr_led, l0, 0, 0);
    add_entry(op_rd, addr_led, 0, 0, l0 & 32'h0000_ffff);
    add_entry(op_led, 0, 0, 0, l0 & 32'h0000_fffe);
    add_entry(op_wr, addr_led, l1, 0, 0);
    add_entry(op_rd, addr_led, 0, 0, l1 & 32'h0000_ffff);
    add_entry(op_led, 0, 0, 0, l1 & 32'h0000_fffe);
    add_entry(op_wr, 4'd5, 32'hffff_ffff, 0, 0);
    add_entry(op_rd, 4'd5, 0, 0, 0);
    add_entry(op_rd, 4'd9, 0, 0, 0);
    add_entry(op_wr, addr_disp, w, 0, 0);
    add_entry(op_scan, 0, 0, 0, w);
    // Running read returns the count from before the sampling edge
    add_entry(op_wr, addr_cnt_ctrl, 32'h2, 0, 0);
    add_entry(op_wr, addr_cnt_ctrl, 32'h1, 0, 0);
    add_entry(op_idle, 0, 20, 0, 0);
    add_entry(op_rd, addr_cnt, 0, 0, 20);
    add_entry(op_rd, addr_cnt_ctrl, 0, 0, 1);
    // Clear while enabled, then seven more counted edges
    add_entry(op_wr, addr_cnt_ctrl, 32'h3, 0, 0);
    add_entry(op_idle, 0, 1, 0, 0);
    add_entry(op_rd, addr_cnt, 0, 0, 0);
    add_entry(op_idle, 0, 5, 0, 0);
    add_entry(op_rd, addr_cnt, 0, 0, 7);
    // Stop write edge still counts, so idle n stops at n+1
    add_entry(op_wr, addr_cnt_ctrl, 32'h2, 0, 0);
    add_entry(op_wr, addr_cnt_ctrl, 32'h1, 0, 0);
    add_entry(op_idle, 0, 10, 0, 0);
    add_entry(op_wr, addr_cnt_ctrl, 32'h0, 0, 0);
    add_entry(op_rd, addr_cnt, 0, 0, 11);
    add_entry(op_rd, addr_cnt_ctrl, 0, 0, 0);
    add_entry(op_rd, addr_status, 0, 0, 0);
    // 301 counts wrap once and leave 45
    add_entry(op_wr, addr_cnt_ctrl, 32'h2, 0, 0);
    add_entry(op_wr, addr_cnt_ctrl, 32'h1, 0, 0);
    add_entry(op_idle, 0, 300, 0, 0);
    add_entry(op_wr, addr_cnt_ctrl, 32'h0, 0, 0);
    add_entry(op_rd, addr_status, 0, 0, 1);
    add_entry(op_led, 0, 0, 0, (l1 & 32'h0000_fffe) | 32'h1);
    add_entry(op_rd, addr_cnt, 0, 0, 45);
    add_entry(op_wr, addr_cnt_ctrl, 32'h2, 0, 0);
    add_entry(op_idle, 0, 1, 0, 0);
    add_entry(op_rd, addr_status, 0, 0, 0);
    add_entry(op_led, 0, 0, 0, l1 & 32'h0000_fffe);
    // Debug view of a stopped count of 0x5d
    add_entry(op_wr, addr_cnt_ctrl, 32'h2, 0, 0);
    add_entry(op_wr, addr_cnt_ctrl, 32'h1, 0, 0);
    add_entry(op_idle, 0, 92, 0, 0);
    add_entry(op_wr, addr_cnt_ctrl, 32'h0, 0, 0);
    add_entry(op_rd, addr_cnt, 0, 0, 32'h5d);
    add_entry(op_scan, 0, 0, 1, 32'h0000_005d);
    add_entry(op_scan, 0, 0, 0, w);
  endtask

  task automatic do_write(input logic [addr_w-1:0] a, input logic [data_w-1:0] d,
                          input logic dbg);
    addr = a;
    wr_data = d;
    debug = dbg;
    wr_en = 1'b1;
    @(negedge clk);
    wr_en = 1'b0;
  endtask

  task automatic do_read(input logic [addr_w-1:0] a, input logic dbg,
                         input logic [data_w-1:0] e);
    addr = a;
    debug = dbg;
    rd_en = 1'b1;
    @(negedge clk);
    rd_en = 1'b0;
    check_val("rd_valid", 1, rd_valid);
    check_val("rd_data", e, rd_data);
    @(negedge clk);
    // Pulse lasts a single cycle
    check_val("rd_valid", 0, rd_valid);
  endtask

  // Two full rounds of digits, checked on every anode change
  task automatic scan_digits(input logic dbg, input logic [data_w-1:0] word);
    logic [7:0] prev_an;
    int prev_idx;
    int idx;
    int waited;
    debug = dbg;
    prev_an = an;
    check_val("an low bits", 1, low_bit_count(prev_an));
    prev_idx = low_bit_index(prev_an);
    for (int n = 0; n < 16; n++) begin
      waited = 0;
      @(negedge clk);
      while (an == prev_an) begin
        waited++;
        if (waited > 2 * scan_div + 2) begin
          $display("Display scan stalled, anode unchanged for %0d cycles", waited);
          $display("test failed");
          $fatal(1, "scan stalled");
        end
        @(negedge clk);
      end
      idx = (prev_idx + 1) % 8;
      check_val("an low bits", 1, low_bit_count(an));
      check_val("an", anode_for(idx), an);
      check_val("sev_out", seg_table[word[idx*4 +: 4]], sev_out);
      prev_an = an;
      prev_idx = idx;
    end
  endtask

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    wr_en = 1'b0;
    rd_en = 1'b0;
    addr = '0;
    wr_data = '0;
    debug = 1'b0;
    init_seg_table();
    build_table();
    limit = n_entries * 40 + 8 * 8 * scan_div + 100;
    repeat (10) @(negedge clk);
    rst = 1'b0;
    check_val("rd_valid", 0, rd_valid);
    check_val("led", 0, led);
    check_val("an", anode_for(0), an);
    check_val("sev_out", seg_table[0], sev_out);
    for (int i = 0; i < n_entries; i++) begin
      case (op_t[i])
        op_wr: do_write(addr_t[i], data_t[i], dbg_t[i]);
        op_rd: do_read(addr_t[i], dbg_t[i], exp_t[i]);
        op_idle: begin
          debug = dbg_t[i];
          repeat (data_t[i]) @(negedge clk);
        end
        op_scan: scan_digits(dbg_t[i], exp_t[i]);
        op_led: check_val("led", exp_t[i], led);
        default: begin
          $display("Table entry %0d holds an unknown operation", i);
          $display("test failed");
          $fatal(1, "bad table entry");
        end
      endcase
    end
    $display("test passed");
    $finish;
  end

endmodule : tb_debug_shell

`default_nettype wire
